// ==== Bender.yml ====
package:
  name: sig_check

sources:
  # Shared package first, then leaves before the blocks that use them
  - common/sig_pkg.sv
  - checksum/hash32.sv
  - checksum/scan_engine.sv
  - source/pattern_ram.sv
  - source/apb_regs.sv
  - source/sig_check_top.sv

  - target: test
    files:
      - sim/tb_sig_check.sv

// ==== checksum/hash32.sv ====
module hash32
    import sig_pkg::*;
#(
    parameter word_t INITIAL_VALUE = 32'h14d6
)
(
    input  logic  clk,
    input  logic  reset,
    input  logic  en,
    input  word_t new_data,
    output word_t value
);

    // Feedback taps that also take the low bit of the current value
    localparam word_t TAP_MASK = 32'h0000_0057;

    word_t shifted;
    word_t next_value;

    always_comb
    begin
        // The value shifts right by one and bit 0 wraps round to bit 31
        shifted = {value[0], value[WORD_W-1:1]};

        // Bits 6, 4, 2, 1 and 0 also fold in the old bit 0
        next_value = new_data ^ shifted;
        if (value[0])
        begin
            next_value = next_value ^ TAP_MASK;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            value <= INITIAL_VALUE;
        end
        else if (en)
        begin
            // One word is absorbed per enabled cycle
            value <= next_value;
        end
    end

endmodule

// ==== checksum/scan_engine.sv ====
module scan_engine
    import sig_pkg::*;
#(
    parameter word_t INITIAL_VALUE = 32'h14d6
)
(
    input  logic        clk,
    input  logic        reset,
    input  logic        scan_start,
    input  ram_addr_t   scan_base,
    input  word_count_t scan_count,
    input  word_t       rd_data,
    output logic        rd_en,
    output ram_addr_t   rd_addr,
    output logic        busy,
    output logic        scan_done,
    output word_t       signature
);

    scan_state_t state;
    word_count_t remaining;
    logic        start_accept;
    logic        hash_en;
    logic        hash_reset;

    // A start is only taken from idle, anything else would corrupt a running hash
    assign start_accept = scan_start && (state == SCAN_IDLE);

    // One read per cycle while words are left in the current scan
    assign rd_en = (state == SCAN_READ) && (remaining != '0);

    // Busy covers the whole scan up to and including the finish cycle
    assign busy      = (state != SCAN_IDLE);
    assign scan_done = (state == SCAN_FINISH);

    // The hash restarts from its seed on the same edge that launches the scan
    assign hash_reset = reset || start_accept;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= SCAN_IDLE;
            remaining <= '0;
            hash_en   <= 1'b0;
        end
        else
        begin
            // Memory data shows up one cycle after the read, so the enable follows it
            hash_en <= rd_en;

            case (state)
                SCAN_IDLE:
                begin
                    if (start_accept)
                    begin
                        state     <= SCAN_READ;
                        remaining <= scan_count;
                    end
                end
                SCAN_READ:
                begin
                    if (remaining != '0)
                    begin
                        remaining <= remaining - 1'b1;
                    end
                    else
                    begin
                        // The last word is being hashed in this cycle
                        state <= SCAN_DRAIN;
                    end
                end
                SCAN_DRAIN:
                begin
                    state <= SCAN_FINISH;
                end
                SCAN_FINISH:
                begin
                    state <= SCAN_IDLE;
                end
                default:
                begin
                    state <= SCAN_IDLE;
                end
            endcase
        end
    end

    // Read pointer wraps at the top of the memory by its own width
    always_ff @(posedge clk)
    begin
        if (start_accept)
        begin
            rd_addr <= scan_base;
        end
        else if (rd_en)
        begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    hash32 #(
        .INITIAL_VALUE (INITIAL_VALUE)
    ) hash32_inst (
        .clk      (clk),
        .reset    (hash_reset),
        .en       (hash_en),
        .new_data (rd_data),
        .value    (signature)
    );

    // The done pulse is one cycle wide and the engine is idle right after it
    assert property (@(posedge clk) disable iff (reset)
        scan_done |=> !scan_done && !busy);

    // The delayed hash enable never outlives the read state, so the signature is final
    assert property (@(posedge clk) disable iff (reset)
        hash_en |-> state == SCAN_READ);

endmodule

// ==== common/sig_pkg.sv ====
package sig_pkg;

    // Data path width shared by APB, the memory and the hash
    localparam int WORD_W = 32;

    // The register map fixes the memory at 256 words
    localparam int RAM_ADDR_W = 8;
    localparam int RAM_DEPTH  = 1 << RAM_ADDR_W;

    // Byte address width of the APB port, enough for eight registers
    localparam int APB_ADDR_W = 5;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [RAM_ADDR_W-1:0] ram_addr_t;
    // One extra bit so that a full-memory scan of 256 words fits
    typedef logic [RAM_ADDR_W:0]   word_count_t;
    typedef logic [APB_ADDR_W-1:0] apb_addr_t;

    // Register offsets
    localparam apb_addr_t REG_CTRL      = 5'h00;
    localparam apb_addr_t REG_STATUS    = 5'h04;
    localparam apb_addr_t REG_ADDR      = 5'h08;
    localparam apb_addr_t REG_BASE      = 5'h0C;
    localparam apb_addr_t REG_COUNT     = 5'h10;
    localparam apb_addr_t REG_DATA      = 5'h14;
    localparam apb_addr_t REG_EXPECT    = 5'h18;
    localparam apb_addr_t REG_SIGNATURE = 5'h1C;

    // Bit positions inside CTRL and STATUS
    localparam int CTRL_START_BIT   = 0;
    localparam int CTRL_CLEAR_BIT   = 1;
    localparam int STATUS_BUSY_BIT  = 0;
    localparam int STATUS_DONE_BIT  = 1;
    localparam int STATUS_MATCH_BIT = 2;

    // Scan engine states
    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_READ,
        SCAN_DRAIN,
        SCAN_FINISH
    } scan_state_t;

endpackage

// ==== project.f ====
common/sig_pkg.sv
checksum/hash32.sv
checksum/scan_engine.sv
source/pattern_ram.sv
source/apb_regs.sv
source/sig_check_top.sv
sim/tb_sig_check.sv

// ==== sim/tb_sig_check.sv ====
module tb_sig_check
    import sig_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // The DUT runs with its default hash start value
    localparam word_t HASH_START = 32'h14d6;
    // Loads, register traffic and scans add up to about 1300 cycles
    localparam int TIMEOUT_CYCLES = 6000;

    logic      clk;
    logic      reset;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    word_t     pwdata;
    word_t     prdata;
    logic      pready;
    logic      pslverr;

    // Expected response for the access phase in progress
    logic      exp_err;
    logic      chk_data;
    logic      chk_status;
    word_t     exp_data;

    word_t     last_rdata;
    word_t     mem_copy [RAM_DEPTH];
    word_t     expect_copy;
    ram_addr_t ptr_copy;
    int        cycle;
    int        start_cycle;
    int        errors;
    int        test_errors;
    int        tests_run;
    int        tests_failed;

    sig_check_top sig_check_top_inst (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #10 clk = ~clk;

    // Cycle count for the timeout and for the scan timing
    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES)
        begin
            $display("Run timed out after %0d cycles", cycle);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // Read data as it stood at the edge that ended the access phase
    always @(posedge clk)
    begin
        if (psel && penable)
        begin
            last_rdata <= prdata;
        end
    end

    assert property (@(posedge clk) (psel && penable) |-> pready)
        else report_mismatch("pready", 32'd1, word_t'($sampled(pready)));
    assert property (@(posedge clk) (psel && penable) |-> pslverr == exp_err)
        else report_mismatch("pslverr", word_t'($sampled(exp_err)), word_t'($sampled(pslverr)));
    assert property (@(posedge clk) (psel && penable && chk_data) |-> prdata == exp_data)
        else report_mismatch("prdata", $sampled(exp_data), $sampled(prdata));
    assert property (@(posedge clk) (psel && penable && chk_status) |-> prdata == exp_data)
        else report_mismatch("status", $sampled(exp_data), $sampled(prdata));

    task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
        $display("CHECK FAILED at %0d ns: %s expected %h, got %h",
                 $time, name, expected, actual);
        errors++;
    endtask

    // Each transfer starts 1 ns after a rising edge and takes a setup and an access cycle
    task automatic apb_write(input apb_addr_t addr, input word_t data, input logic err);
        paddr  = addr;
        pwdata = data;
        pwrite = 1'b1;
        psel   = 1'b1;
        @(posedge clk);
        #1;
        penable = 1'b1;
        exp_err = err;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, input word_t expected, input logic err);
        paddr  = addr;
        pwrite = 1'b0;
        psel   = 1'b1;
        @(posedge clk);
        #1;
        penable    = 1'b1;
        exp_err    = err;
        exp_data   = expected;
        chk_status = (addr == REG_STATUS);
        chk_data   = (addr != REG_STATUS);
        @(posedge clk);
        #1;
        psel       = 1'b0;
        penable    = 1'b0;
        chk_data   = 1'b0;
        chk_status = 1'b0;
    endtask

    // Loads random words from the given address and keeps a copy for the model
    task automatic load_words(input int first, input int n);
        word_t d;
        int    k;
        ptr_copy = ram_addr_t'(first);
        apb_write(REG_ADDR, word_t'(first), 1'b0);
        for (k = 0; k < n; k++)
        begin
            d = $urandom();
            mem_copy[ptr_copy] = d;
            apb_write(REG_DATA, d, 1'b0);
            ptr_copy++;
        end
    endtask

    // Signature from the shift-and-XOR rule over the copy of the memory
    function automatic word_t model_signature(input int base, input int count);
        word_t v;
        word_t nv;
        word_t d;
        int    k;
        int    i;
        v = HASH_START;
        for (k = 0; k < count; k++)
        begin
            d = mem_copy[(base + k) % RAM_DEPTH];
            nv[31] = d[31] ^ v[0];
            for (i = 30; i >= 0; i--)
            begin
                nv[i] = d[i] ^ v[i+1];
            end
            // Low bit feeds back into five taps
            nv[6] = nv[6] ^ v[0];
            nv[4] = nv[4] ^ v[0];
            nv[2] = nv[2] ^ v[0];
            nv[1] = nv[1] ^ v[0];
            nv[0] = nv[0] ^ v[0];
            v = nv;
        end
        return v;
    endfunction

    // STATUS seen by a read called now. Its access phase samples the registers
    // one edge later, and done lands count+3 edges after the start write
    function automatic word_t expected_status(input int count, input logic match);
        int    elapsed;
        word_t status;
        elapsed = cycle + 1 - start_cycle;
        status = '0;
        status[STATUS_BUSY_BIT]  = (elapsed < count + 3);
        status[STATUS_DONE_BIT]  = (elapsed >= count + 3);
        status[STATUS_MATCH_BIT] = (elapsed >= count + 3) && match;
        return status;
    endfunction

    task automatic setup_scan(input int base, input int count, input word_t expect_word);
        apb_write(REG_BASE, word_t'(base), 1'b0);
        apb_write(REG_COUNT, word_t'(count), 1'b0);
        apb_write(REG_EXPECT, expect_word, 1'b0);
        expect_copy = expect_word;
    endtask

    task automatic start_scan();
        apb_write(REG_CTRL, 32'h1, 1'b0);
        start_cycle = cycle;
    endtask

    // Polls STATUS until done, each poll checked against the cycle count
    task automatic finish_scan(input int base, input int count);
        word_t model;
        logic  match;
        int    polls;
        model = model_signature(base, count);
        match = (model == expect_copy);
        polls = 0;
        last_rdata = '0;
        while (!last_rdata[STATUS_DONE_BIT] && polls <= count / 2 + 4)
        begin
            apb_read(REG_STATUS, expected_status(count, match), 1'b0);
            polls++;
        end
        if (!last_rdata[STATUS_DONE_BIT])
        begin
            $display("Scan of %0d words never reported done", count);
            errors++;
        end
        apb_read(REG_SIGNATURE, model, 1'b0);
        apb_read(REG_STATUS, expected_status(count, match), 1'b0);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_errors)
        begin
            tests_failed++;
            $display("Test %0d, %s: failed", tests_run, name);
        end
        else
        begin
            $display("Test %0d, %s: passed", tests_run, name);
        end
        test_errors = errors;
    endtask

    initial
    begin
        clk         = 1'b0;
        reset       = 1'b1;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        exp_err     = 1'b0;
        chk_data    = 1'b0;
        chk_status  = 1'b0;
        exp_data    = '0;
        last_rdata  = '0;
        expect_copy = '0;
        ptr_copy    = '0;
        cycle       = 0;
        start_cycle = 0;
        errors      = 0;
        test_errors = 0;
        tests_run   = 0;
        tests_failed = 0;
        void'($urandom(32'h0859_2578));
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        apb_read(REG_STATUS, '0, 1'b0);
        apb_read(REG_SIGNATURE, '0, 1'b0);
        apb_read(REG_ADDR, '0, 1'b0);
        apb_read(REG_COUNT, '0, 1'b0);
        apb_read(REG_DATA, '0, 1'b0);
        end_test("reset values");

        load_words(0, 64);
        setup_scan(0, 64, model_signature(0, 64));
        apb_read(REG_COUNT, 32'd64, 1'b0);
        start_scan();
        finish_scan(0, 64);
        end_test("scan of 64 words");

        // The previous scan matched, so this clear has a set match bit to drop
        apb_write(REG_CTRL, 32'h2, 1'b0);
        apb_read(REG_STATUS, '0, 1'b0);
        setup_scan(0, 64, ~model_signature(0, 64));
        start_scan();
        finish_scan(0, 64);
        apb_write(REG_CTRL, 32'h2, 1'b0);
        apb_read(REG_STATUS, '0, 1'b0);
        end_test("mismatch and clear");

        setup_scan(0, 0, HASH_START);
        start_scan();
        finish_scan(0, 0);
        load_words(250, 6);
        // Lengths past the memory size read back as a full scan
        apb_write(REG_COUNT, 32'd300, 1'b0);
        apb_read(REG_COUNT, 32'd256, 1'b0);
        setup_scan(250, 10, model_signature(250, 10));
        start_scan();
        finish_scan(250, 10);
        end_test("empty and wrapping scans");

        // 0x1F is the highest offset past the map that a 5-bit address can carry
        apb_write(5'h1F, 32'h1, 1'b1);
        apb_read(5'h1F, '0, 1'b1);
        apb_write(5'h06, 32'h1, 1'b1);
        apb_write(REG_STATUS, 32'h7, 1'b1);
        apb_write(REG_SIGNATURE, 32'h1, 1'b1);
        setup_scan(0, 64, model_signature(0, 64));
        start_scan();
        apb_write(REG_DATA, 32'hdead_beef, 1'b1);
        apb_write(REG_BASE, 32'd5, 1'b1);
        apb_write(REG_COUNT, 32'd3, 1'b1);
        apb_write(REG_CTRL, 32'h1, 1'b0);
        finish_scan(0, 64);
        apb_read(REG_BASE, '0, 1'b0);
        apb_read(REG_ADDR, word_t'(ptr_copy), 1'b0);
        end_test("errors and writes while busy");

        load_words(64, 186);
        setup_scan(0, 200, model_signature(0, 200));
        start_scan();
        finish_scan(0, 200);
        // One idle cycle moves the polls onto the other edge parity
        start_scan();
        @(posedge clk);
        #1;
        finish_scan(0, 200);
        end_test("timing of a 200-word scan");

        $display("%0d tests run, %0d failed, %0d check failures", tests_run, tests_failed, errors);
        if (errors == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== source/apb_regs.sv ====
module apb_regs
    import sig_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  apb_addr_t   paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  word_t       pwdata,
    input  logic        busy,
    input  logic        scan_done,
    input  word_t       signature,
    output word_t       prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        wr_en,
    output ram_addr_t   wr_addr,
    output word_t       wr_data,
    output logic        scan_start,
    output ram_addr_t   scan_base,
    output word_count_t scan_count
);

    logic      access;
    logic      addr_ok;
    logic      ro_hit;
    logic      busy_hit;
    logic      reg_err;
    logic      wr_ok;
    logic      ctrl_wr;
    logic      clear;
    logic      done;
    logic      match;
    ram_addr_t wr_ptr;
    word_t     expect_value;
    word_t     sig_value;

    // No wait states, every transfer finishes in its access cycle
    assign pready = 1'b1;
    assign access = psel && penable;

    // Word-aligned offsets inside the register map are the only legal ones
    assign addr_ok = (paddr[1:0] == 2'b00) && (paddr <= REG_SIGNATURE);
    assign ro_hit  = (paddr == REG_STATUS) || (paddr == REG_SIGNATURE);

    // Scan setup and memory contents are locked while a scan runs
    assign busy_hit = busy && ((paddr == REG_DATA) || (paddr == REG_BASE) ||
                               (paddr == REG_COUNT));

    assign reg_err = !addr_ok || (pwrite && (ro_hit || busy_hit));
    assign pslverr = access && reg_err;
    assign wr_ok   = access && pwrite && !reg_err;

    // CTRL bits act as pulses and are never stored
    assign ctrl_wr    = wr_ok && (paddr == REG_CTRL);
    assign scan_start = ctrl_wr && pwdata[CTRL_START_BIT] && !busy;
    assign clear      = ctrl_wr && pwdata[CTRL_CLEAR_BIT];

    // DATA writes go straight to the memory at the current pointer
    assign wr_en   = wr_ok && (paddr == REG_DATA);
    assign wr_addr = wr_ptr;
    assign wr_data = pwdata;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr       <= '0;
            scan_base    <= '0;
            scan_count   <= '0;
            expect_value <= '0;
        end
        else if (wr_ok)
        begin
            case (paddr)
                REG_ADDR:
                begin
                    wr_ptr <= pwdata[RAM_ADDR_W-1:0];
                end
                REG_DATA:
                begin
                    // Pointer steps on so a block of words loads with DATA writes only
                    wr_ptr <= wr_ptr + 1'b1;
                end
                REG_BASE:
                begin
                    scan_base <= pwdata[RAM_ADDR_W-1:0];
                end
                REG_COUNT:
                begin
                    // Lengths past the memory size saturate at a full scan
                    if (pwdata > word_t'(RAM_DEPTH))
                    begin
                        scan_count <= word_count_t'(RAM_DEPTH);
                    end
                    else
                    begin
                        scan_count <= pwdata[RAM_ADDR_W:0];
                    end
                end
                REG_EXPECT:
                begin
                    expect_value <= pwdata;
                end
                default:
                begin
                end
            endcase
        end
    end

    // Sticky status. A finishing scan wins over a clear in the same cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            done      <= 1'b0;
            match     <= 1'b0;
            sig_value <= '0;
        end
        else if (scan_done)
        begin
            done      <= 1'b1;
            match     <= (signature == expect_value);
            sig_value <= signature;
        end
        else if (clear || scan_start)
        begin
            // A new scan also drops the result of the previous one
            done  <= 1'b0;
            match <= 1'b0;
        end
    end

    // Read mux. Write-only and illegal offsets return 0
    always_comb
    begin
        prdata = '0;
        case (paddr)
            REG_STATUS:
            begin
                prdata[STATUS_BUSY_BIT]  = busy;
                prdata[STATUS_DONE_BIT]  = done;
                prdata[STATUS_MATCH_BIT] = match;
            end
            REG_ADDR:      prdata = word_t'(wr_ptr);
            REG_BASE:      prdata = word_t'(scan_base);
            REG_COUNT:     prdata = word_t'(scan_count);
            REG_EXPECT:    prdata = expect_value;
            REG_SIGNATURE: prdata = sig_value;
            default:       prdata = '0;
        endcase
    end

    // The master keeps psel up through the access phase
    assert property (@(posedge clk) disable iff (reset)
        penable |-> psel);

    // Every start launches the engine, which reports busy from the next cycle
    assert property (@(posedge clk) disable iff (reset)
        scan_start |=> busy);

endmodule

// ==== source/pattern_ram.sv ====
module pattern_ram
    import sig_pkg::*;
(
    input  logic      clk,
    input  logic      wr_en,
    input  ram_addr_t wr_addr,
    input  word_t     wr_data,
    input  logic      rd_en,
    input  ram_addr_t rd_addr,
    output word_t     rd_data
);

    // Plain array so that synthesis maps it onto one simple dual-port block RAM
    word_t mem [RAM_DEPTH];

    // Write port, driven from the APB side
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read port with its output register, holding the last word between reads
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rd_data <= mem[rd_addr];
        end
    end

    // A read and a write to the same address in one cycle returns the old word
    // which is harmless here since the APB side cannot write data while busy

endmodule

// ==== source/sig_check_top.sv ====
module sig_check_top
    import sig_pkg::*;
#(
    parameter word_t INITIAL_VALUE = 32'h14d6
)
(
    input  logic      clk,
    input  logic      reset,
    input  apb_addr_t paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  word_t     pwdata,
    output word_t     prdata,
    output logic      pready,
    output logic      pslverr
);

    // Memory write port from the register block
    logic        wr_en;
    ram_addr_t   wr_addr;
    word_t       wr_data;

    // Memory read port from the scan engine
    logic        rd_en;
    ram_addr_t   rd_addr;
    word_t       rd_data;

    // Scan control and result
    logic        scan_start;
    ram_addr_t   scan_base;
    word_count_t scan_count;
    logic        busy;
    logic        scan_done;
    word_t       signature;

    apb_regs apb_regs_inst (
        .clk        (clk),
        .reset      (reset),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .busy       (busy),
        .scan_done  (scan_done),
        .signature  (signature),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .scan_start (scan_start),
        .scan_base  (scan_base),
        .scan_count (scan_count)
    );

    pattern_ram pattern_ram_inst (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    scan_engine #(
        .INITIAL_VALUE (INITIAL_VALUE)
    ) scan_engine_inst (
        .clk        (clk),
        .reset      (reset),
        .scan_start (scan_start),
        .scan_base  (scan_base),
        .scan_count (scan_count),
        .rd_data    (rd_data),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .busy       (busy),
        .scan_done  (scan_done),
        .signature  (signature)
    );

endmodule
